// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module dmem_subsys_tb -Mdir obj_dir
	./obj_dir/Vdmem_subsys_tb

clean:
	rm -rf obj_dir

// ==== bench/dmem_subsys_tb.sv ====
// ============================================================
// testbench for the data memory subsystem
// directed table of loads and stores, then LFSR-random traffic
// checked against a byte-array model of the memory
// ============================================================
`timescale 1ns/1ns
`include "dmem_defines.svh"

module dmem_subsys_tb;

	localparam int RANDOM_OPS = 40;
	localparam int MAX_WAIT = 20;

	// one table row, rdata is only used by loads and wdata only by stores
	typedef struct packed
	{
		dmem_pkg::mem_op_t op;
		dmem_pkg::mem_funct3_t funct3;
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr;
		logic [`DWORD_SIZE_BITS-1:0] wdata;
		logic [`DWORD_SIZE_BITS-1:0] rdata;
		logic poke;
	} table_entry_t;

	logic clock;
	logic reset;
	dmem_pkg::cpu_req_t req;
	logic busy;
	dmem_pkg::cpu_resp_t resp;

	table_entry_t stim [$];
	logic [7:0] model_bytes [1 << `DMEM_BYTE_ADDR_SIZE];
	bit model_written [1 << `DMEM_BYTE_ADDR_SIZE];
	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int cycle_limit;

	dmem_subsys uut
	(
		.clock(clock),
		.reset(reset),
		.req(req),
		.busy(busy),
		.resp(resp)
	);

	initial
	begin
		clock = 1'b0;
	end

	always #5 clock = ~clock;

	// the run is bounded by the table length plus the random operations
	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout after %0d cycles without finishing the tests", cycle_count);
			$display("Test failed");
			$fatal(1);
		end
	end

	task automatic stop_with_failure(string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_word(string name, logic [`DWORD_SIZE_BITS-1:0] expected,
		logic [`DWORD_SIZE_BITS-1:0] actual);
		if (actual !== expected)
		begin
			stop_with_failure($sformatf("[FAIL] time %0t %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	task automatic check_flag(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			stop_with_failure($sformatf("[FAIL] time %0t %s expected %b actual %b",
				$time, name, expected, actual));
		end
	endtask

	// Galois LFSR, one step for every bit handed out
	function automatic logic [31:0] random_bits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	// bytes touched by a funct3, halves and words are aligned down
	function automatic int access_size(dmem_pkg::mem_funct3_t funct3);
		case (funct3)
			dmem_pkg::LB, dmem_pkg::LBU: return 1;
			dmem_pkg::LH, dmem_pkg::LHU: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic void model_store(dmem_pkg::mem_funct3_t funct3,
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr, logic [`DWORD_SIZE_BITS-1:0] wdata);
		int size;
		int base;
		size = access_size(funct3);
		base = int'(addr) & ~(size - 1);
		for (int i = 0; i < size; i++)
		begin
			model_bytes[base + i] = wdata[8*i +: 8];
			model_written[base + i] = 1'b1;
		end
	endfunction

	// a load is only predictable when every byte it reads was stored before
	function automatic logic model_known(dmem_pkg::mem_funct3_t funct3,
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr);
		int size;
		int base;
		logic known;
		size = access_size(funct3);
		base = int'(addr) & ~(size - 1);
		known = 1'b1;
		for (int i = 0; i < size; i++)
		begin
			known = known & model_written[base + i];
		end
		return known;
	endfunction

	function automatic logic [31:0] model_load(dmem_pkg::mem_funct3_t funct3,
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr);
		int size;
		int base;
		logic [31:0] value;
		size = access_size(funct3);
		base = int'(addr) & ~(size - 1);
		value = '0;
		for (int i = 0; i < size; i++)
		begin
			value[8*i +: 8] = model_bytes[base + i];
		end
		// unsigned loads are already zero filled above the loaded bytes
		case (funct3)
			dmem_pkg::LB: value = {{24{value[7]}}, value[7:0]};
			dmem_pkg::LH: value = {{16{value[15]}}, value[15:0]};
			default: value = value;
		endcase
		return value;
	endfunction

	function automatic dmem_pkg::mem_funct3_t pick_funct3(dmem_pkg::mem_op_t op, int pick);
		dmem_pkg::mem_funct3_t funct3;
		if (op == dmem_pkg::OP_STORE)
		begin
			case (pick % 3)
				0: funct3 = dmem_pkg::SB;
				1: funct3 = dmem_pkg::SH;
				default: funct3 = dmem_pkg::SW;
			endcase
		end
		else
		begin
			case (pick % 5)
				0: funct3 = dmem_pkg::LB;
				1: funct3 = dmem_pkg::LH;
				2: funct3 = dmem_pkg::LW;
				3: funct3 = dmem_pkg::LBU;
				default: funct3 = dmem_pkg::LHU;
			endcase
		end
		return funct3;
	endfunction

	function automatic void add_store(dmem_pkg::mem_funct3_t funct3,
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr, logic [31:0] wdata, logic poke);
		stim.push_back({dmem_pkg::OP_STORE, funct3, addr, wdata, 32'h0, poke});
	endfunction

	function automatic void add_load(dmem_pkg::mem_funct3_t funct3,
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr, logic [31:0] rdata, logic poke);
		stim.push_back({dmem_pkg::OP_LOAD, funct3, addr, 32'h0, rdata, poke});
	endfunction

	function automatic void fill_table();
		// whole words in several blocks and word slots
		add_store(dmem_pkg::SW, 10'h010, 32'h1122_3344, 1'b0);
		add_store(dmem_pkg::SW, 10'h014, 32'hA5B6_C7D8, 1'b0);
		add_store(dmem_pkg::SW, 10'h018, 32'h0F1E_2D3C, 1'b0);
		add_store(dmem_pkg::SW, 10'h01C, 32'h8070_6050, 1'b0);
		add_store(dmem_pkg::SW, 10'h3F4, 32'hDEAD_BEEF, 1'b0);
		add_store(dmem_pkg::SW, 10'h05C, 32'h1357_9BDF, 1'b0);
		add_load(dmem_pkg::LW, 10'h010, 32'h1122_3344, 1'b0);
		add_load(dmem_pkg::LW, 10'h3F4, 32'hDEAD_BEEF, 1'b0);
		add_load(dmem_pkg::LW, 10'h01C, 32'h8070_6050, 1'b0);
		add_load(dmem_pkg::LW, 10'h05C, 32'h1357_9BDF, 1'b0);
		// byte and half stores only change their own bytes, upper wdata is ignored
		add_store(dmem_pkg::SB, 10'h011, 32'h0000_00EE, 1'b0);
		add_store(dmem_pkg::SH, 10'h012, 32'h0000_7A7B, 1'b0);
		add_store(dmem_pkg::SB, 10'h3F7, 32'hFFFF_FF12, 1'b0);
		add_store(dmem_pkg::SH, 10'h05D, 32'hFFFF_0042, 1'b0);
		add_load(dmem_pkg::LW, 10'h010, 32'h7A7B_EE44, 1'b0);
		add_load(dmem_pkg::LW, 10'h014, 32'hA5B6_C7D8, 1'b0);
		add_load(dmem_pkg::LW, 10'h018, 32'h0F1E_2D3C, 1'b0);
		add_load(dmem_pkg::LW, 10'h01C, 32'h8070_6050, 1'b0);
		add_load(dmem_pkg::LW, 10'h3F4, 32'h12AD_BEEF, 1'b0);
		add_load(dmem_pkg::LW, 10'h05C, 32'h1357_0042, 1'b0);
		// word at 014 has the top bit set in every byte and half
		add_load(dmem_pkg::LB, 10'h014, 32'hFFFF_FFD8, 1'b0);
		add_load(dmem_pkg::LB, 10'h015, 32'hFFFF_FFC7, 1'b0);
		add_load(dmem_pkg::LB, 10'h016, 32'hFFFF_FFB6, 1'b0);
		add_load(dmem_pkg::LB, 10'h017, 32'hFFFF_FFA5, 1'b0);
		add_load(dmem_pkg::LBU, 10'h014, 32'h0000_00D8, 1'b0);
		add_load(dmem_pkg::LBU, 10'h015, 32'h0000_00C7, 1'b0);
		add_load(dmem_pkg::LBU, 10'h016, 32'h0000_00B6, 1'b0);
		add_load(dmem_pkg::LBU, 10'h017, 32'h0000_00A5, 1'b0);
		add_load(dmem_pkg::LH, 10'h014, 32'hFFFF_C7D8, 1'b0);
		add_load(dmem_pkg::LH, 10'h016, 32'hFFFF_A5B6, 1'b0);
		add_load(dmem_pkg::LHU, 10'h014, 32'h0000_C7D8, 1'b0);
		add_load(dmem_pkg::LHU, 10'h016, 32'h0000_A5B6, 1'b0);
		// word at 018 has the top bit clear everywhere
		add_load(dmem_pkg::LB, 10'h018, 32'h0000_003C, 1'b0);
		add_load(dmem_pkg::LB, 10'h019, 32'h0000_002D, 1'b0);
		add_load(dmem_pkg::LB, 10'h01A, 32'h0000_001E, 1'b0);
		add_load(dmem_pkg::LB, 10'h01B, 32'h0000_000F, 1'b0);
		add_load(dmem_pkg::LBU, 10'h018, 32'h0000_003C, 1'b0);
		add_load(dmem_pkg::LBU, 10'h019, 32'h0000_002D, 1'b0);
		add_load(dmem_pkg::LBU, 10'h01A, 32'h0000_001E, 1'b0);
		add_load(dmem_pkg::LBU, 10'h01B, 32'h0000_000F, 1'b0);
		add_load(dmem_pkg::LH, 10'h018, 32'h0000_2D3C, 1'b0);
		add_load(dmem_pkg::LH, 10'h01A, 32'h0000_0F1E, 1'b0);
		add_load(dmem_pkg::LHU, 10'h018, 32'h0000_2D3C, 1'b0);
		add_load(dmem_pkg::LHU, 10'h01A, 32'h0000_0F1E, 1'b0);
		// misaligned halves and words fall back to the aligned address
		add_load(dmem_pkg::LH, 10'h017, 32'hFFFF_A5B6, 1'b0);
		add_load(dmem_pkg::LHU, 10'h015, 32'h0000_C7D8, 1'b0);
		add_load(dmem_pkg::LW, 10'h016, 32'hA5B6_C7D8, 1'b0);
		add_load(dmem_pkg::LW, 10'h01B, 32'h0F1E_2D3C, 1'b0);
		// a store offered while busy must leave the word alone
		add_store(dmem_pkg::SW, 10'h020, 32'hCAFE_F00D, 1'b1);
		add_load(dmem_pkg::LW, 10'h020, 32'hCAFE_F00D, 1'b1);
		add_load(dmem_pkg::LW, 10'h020, 32'hCAFE_F00D, 1'b0);
	endfunction

	// outputs are sampled on the falling edge where they are settled
	task automatic idle_cycles(int count);
		repeat (count)
		begin
			@(negedge clock);
			check_flag("busy", 1'b0, busy);
			check_flag("load_valid", 1'b0, resp.load_valid);
			check_flag("store_done", 1'b0, resp.store_done);
		end
	endtask

	// strobe one request and wait for its response pulse
	task automatic run_op(table_entry_t entry, output logic [`DWORD_SIZE_BITS-1:0] rdata);
		int waited;
		check_flag("busy", 1'b0, busy);
		req.valid = 1'b1;
		req.op = entry.op;
		req.funct3 = entry.funct3;
		req.addr = entry.addr;
		req.wdata = entry.wdata;
		@(negedge clock);
		req.valid = 1'b0;
		check_flag("busy", 1'b1, busy);
		// the fields of a request that arrives while busy
		req.op = dmem_pkg::OP_STORE;
		req.funct3 = dmem_pkg::SW;
		req.wdata = ~entry.wdata;
		waited = 0;
		while (!resp.load_valid && !resp.store_done)
		begin
			if (waited >= MAX_WAIT)
			begin
				stop_with_failure("no response pulse arrived for the request");
			end
			req.valid = entry.poke && (waited == 2);
			@(negedge clock);
			waited++;
		end
		req.valid = 1'b0;
		if (entry.op == dmem_pkg::OP_LOAD && resp.store_done)
		begin
			stop_with_failure("store_done pulsed in response to a load");
		end
		if (entry.op == dmem_pkg::OP_STORE && resp.load_valid)
		begin
			stop_with_failure("load_valid pulsed in response to a store");
		end
		check_flag("busy", 1'b0, busy);
		rdata = resp.rdata;
	endtask

	initial
	begin
		logic [`DWORD_SIZE_BITS-1:0] rdata;
		table_entry_t entry;
		int pick;
		lfsr_state = 32'h3166_fdab;
		req = '0;
		reset = 1'b0;
		fill_table();
		cycle_limit = (stim.size() + RANDOM_OPS) * 16 + 50;
		repeat (4) @(negedge clock);
		reset = 1'b1;
		idle_cycles(4);
		// every row starts on the cycle the previous response shows
		foreach (stim[i])
		begin
			run_op(stim[i], rdata);
			if (stim[i].op == dmem_pkg::OP_LOAD)
			begin
				check_word("rdata", stim[i].rdata, rdata);
			end
			else
			begin
				model_store(stim[i].funct3, stim[i].addr, stim[i].wdata);
			end
			if (stim[i].poke)
			begin
				idle_cycles(2);
			end
		end
		// random traffic kept to the first four blocks so loads find written bytes
		for (int n = 0; n < RANDOM_OPS; n++)
		begin
			entry = '0;
			entry.op = (random_bits(1) != 0) ? dmem_pkg::OP_STORE : dmem_pkg::OP_LOAD;
			pick = int'(random_bits(3));
			entry.addr = `DMEM_BYTE_ADDR_SIZE'(random_bits(6));
			entry.wdata = random_bits(32);
			entry.funct3 = pick_funct3(entry.op, pick);
			if (entry.op == dmem_pkg::OP_LOAD && !model_known(entry.funct3, entry.addr))
			begin
				entry.op = dmem_pkg::OP_STORE;
				entry.funct3 = dmem_pkg::SW;
			end
			run_op(entry, rdata);
			if (entry.op == dmem_pkg::OP_LOAD)
			begin
				check_word("rdata", model_load(entry.funct3, entry.addr), rdata);
			end
			else
			begin
				model_store(entry.funct3, entry.addr, entry.wdata);
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/dmem_pkg.sv
hdl/dmem.sv
hdl/mem_request_seq.sv
hdl/load_align.sv
hdl/dmem_subsys.sv
bench/dmem_subsys_tb.sv

// ==== hdl/dmem.sv ====
// ============================================================
// block data memory with a fixed access delay
// a read raises ready with the block on dout, a write raises done
// ============================================================
`timescale 1ns/1ns
`include "dmem_defines.svh"

module dmem
(
	input logic clock,
	input logic reset,
	input dmem_pkg::blk_req_t blk_req,
	output dmem_pkg::blk_rsp_t blk_rsp
);

	// storage is one flat block per entry
	logic [`DBLOCK_SIZE_BITS-1:0] mem [`DMEM_SIZE_BLOCKS];

	logic [`DMEM_DELAY_CNTR_SIZE-1:0] delay_cnt;
	logic delayed;
	logic one_req;
	logic read_hit;
	logic write_hit;
	logic ready_q;
	logic done_q;
	logic din_taken;
	logic [`DBLOCK_SIZE_BITS-1:0] din_q;

	// the counter only runs while exactly one request line is up
	assign one_req = blk_req.ren ^ blk_req.wen;
	assign delayed = &delay_cnt;

	// the access completes once the counter has saturated
	assign read_hit = delayed && blk_req.ren && !blk_req.wen;
	assign write_hit = delayed && blk_req.wen && !blk_req.ren;

	// both lines low for a cycle bring the counter back to zero
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			delay_cnt <= '0;
		end
		else if (!one_req)
		begin
			delay_cnt <= '0;
		end
		else if (!delayed)
		begin
			delay_cnt <= delay_cnt + 1'b1;
		end
	end

	// ready and done are registered, so they trail the saturated counter by a cycle
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			ready_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			ready_q <= read_hit;
			done_q <= write_hit;
		end
	end

	// write data is taken on the first cycle of wen and held for the whole access
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			din_taken <= 1'b0;
		end
		else
		begin
			din_taken <= blk_req.wen && !blk_req.ren;
		end
	end

	always_ff @(posedge clock)
	begin
		if (blk_req.wen && !blk_req.ren && !din_taken)
		begin
			din_q <= blk_req.din;
		end
		// the block lands in memory on the edge that raises done
		if (write_hit)
		begin
			mem[blk_req.block_address] <= din_q;
		end
	end

	// the addressed block is shown only while ready is high
	assign blk_rsp.ready = ready_q;
	assign blk_rsp.done = done_q;
	assign blk_rsp.dout = ready_q ? mem[blk_req.block_address] : '0;

	// a read and a write at once would corrupt the delay count
	assert property (@(posedge clock) disable iff (!reset) !(blk_req.ren && blk_req.wen))
		else $error("dmem: ren and wen both high");

endmodule

// ==== hdl/dmem_defines.svh ====
// ============================================================
// data memory sizes shared by the package and the RTL
// word, block, memory depth and access delay widths
// ============================================================
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// one word is a RISC-V register width
`define DWORD_SIZE_BITS 32
// a block is the unit that the memory moves per access
`define DBLOCK_SIZE_WORDS 4
`define DBLOCK_SIZE_BITS 128

// depth of the memory and width of its block address
`define DMEM_SIZE_BLOCKS 64
`define DMEM_BLOCK_ADDR_SIZE 6

// byte address is block address, 2-bit word index and 2-bit byte offset
`define DMEM_BYTE_ADDR_SIZE 10

// access delay is 2 to this power in cycles
`define DMEM_DELAY_CNTR_SIZE 2

`endif

// ==== hdl/dmem_pkg.sv ====
// ============================================================
// data memory types
// funct3 codes, processor and block bus structs, word views
// ============================================================
`include "dmem_defines.svh"

package dmem_pkg;

	// RISC-V load funct3 codes
	typedef enum logic [2:0]
	{
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd4,
		LHU = 3'd5
	} mem_funct3_t;

	// store codes reuse the low three load codes
	localparam mem_funct3_t SB = LB;
	localparam mem_funct3_t SH = LH;
	localparam mem_funct3_t SW = LW;

	typedef enum logic
	{
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} mem_op_t;

	// a word seen as flat bits, as bytes or as halves
	typedef union packed
	{
		logic [`DWORD_SIZE_BITS-1:0] bits;
		logic [3:0][7:0] bytes;
		logic [1:0][15:0] halves;
	} dword_u;

	// a block seen as flat bits or as words, word 0 in the low bits
	typedef union packed
	{
		logic [`DBLOCK_SIZE_BITS-1:0] bits;
		dword_u [`DBLOCK_SIZE_WORDS-1:0] words;
	} dblock_u;

	// one processor request, sampled while valid is high and busy is low
	typedef struct packed
	{
		logic valid;
		mem_op_t op;
		mem_funct3_t funct3;
		logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr;
		logic [`DWORD_SIZE_BITS-1:0] wdata;
	} cpu_req_t;

	typedef struct packed
	{
		logic load_valid;
		logic store_done;
		logic [`DWORD_SIZE_BITS-1:0] rdata;
	} cpu_resp_t;

	// block memory request, ren and wen are held until ready or done
	typedef struct packed
	{
		logic ren;
		logic wen;
		logic [`DMEM_BLOCK_ADDR_SIZE-1:0] block_address;
		logic [`DBLOCK_SIZE_BITS-1:0] din;
	} blk_req_t;

	typedef struct packed
	{
		logic ready;
		logic done;
		logic [`DBLOCK_SIZE_BITS-1:0] dout;
	} blk_rsp_t;

endpackage

// ==== hdl/dmem_subsys.sv ====
// ============================================================
// data memory subsystem
// sequencer, block memory and load aligner behind one port
// ============================================================
`timescale 1ns/1ns

module dmem_subsys
(
	input logic clock,
	input logic reset,
	input dmem_pkg::cpu_req_t req,
	output logic busy,
	output dmem_pkg::cpu_resp_t resp
);

	dmem_pkg::blk_req_t blk_req;
	dmem_pkg::blk_rsp_t blk_rsp;
	logic load_strobe;
	dmem_pkg::mem_funct3_t load_funct3;
	logic [3:0] load_offset;
	logic store_done;
	logic load_valid;
	logic [31:0] rdata;

	// sequencer produces block requests
	mem_request_seq u_seq
	(
		.clock(clock),
		.reset(reset),
		.req(req),
		.busy(busy),
		.blk_req(blk_req),
		.blk_rsp(blk_rsp),
		.load_strobe(load_strobe),
		.load_funct3(load_funct3),
		.load_offset(load_offset),
		.store_done(store_done)
	);

	dmem u_dmem
	(
		.clock(clock),
		.reset(reset),
		.blk_req(blk_req),
		.blk_rsp(blk_rsp)
	);

	// aligner consumes the block returned with ready
	load_align u_align
	(
		.clock(clock),
		.reset(reset),
		.load_strobe(load_strobe),
		.load_funct3(load_funct3),
		.load_offset(load_offset),
		.block(blk_rsp.dout),
		.resp_rdata(rdata),
		.load_valid(load_valid)
	);

	assign resp.load_valid = load_valid;
	assign resp.store_done = store_done;
	assign resp.rdata = rdata;

endmodule

// ==== hdl/load_align.sv ====
// ============================================================
// load aligner
// picks the addressed byte, half or word and extends it
// ============================================================
`timescale 1ns/1ns

module load_align
(
	input logic clock,
	input logic reset,
	input logic load_strobe,
	input dmem_pkg::mem_funct3_t load_funct3,
	input logic [3:0] load_offset,
	input dmem_pkg::dblock_u block,
	output logic [31:0] resp_rdata,
	output logic load_valid
);

	dmem_pkg::dword_u word;
	logic [7:0] sel_byte;
	logic [15:0] sel_half;
	logic [31:0] extended;

	// word from bits 3:2, then byte from 1:0 or half from bit 1
	assign word = block.words[load_offset[3:2]];
	assign sel_byte = word.bytes[load_offset[1:0]];
	assign sel_half = word.halves[load_offset[1]];

	// signed loads copy the top bit, unsigned loads fill with zeros
	always_comb
	begin
		case (load_funct3)
			dmem_pkg::LB: extended = {{24{sel_byte[7]}}, sel_byte};
			dmem_pkg::LH: extended = {{16{sel_half[15]}}, sel_half};
			dmem_pkg::LW: extended = word.bits;
			dmem_pkg::LBU: extended = {24'd0, sel_byte};
			dmem_pkg::LHU: extended = {16'd0, sel_half};
			default: extended = '0;
		endcase
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			load_valid <= 1'b0;
		end
		else
		begin
			load_valid <= load_strobe;
		end
	end

	// rdata only changes on a strobe and stays put between loads
	always_ff @(posedge clock)
	begin
		if (load_strobe)
		begin
			resp_rdata <= extended;
		end
	end

	// the sequencer only strobes for loads, never with a store code above LW
	assert property (@(posedge clock) disable iff (!reset)
		load_strobe |-> load_funct3 inside {dmem_pkg::LB, dmem_pkg::LH, dmem_pkg::LW,
			dmem_pkg::LBU, dmem_pkg::LHU})
		else $error("load_align: strobe with a non-load funct3");

endmodule

// ==== hdl/mem_request_seq.sv ====
// ============================================================
// load/store sequencer for the block memory
// loads read one block, stores read, merge and write it back
// ============================================================
`timescale 1ns/1ns
`include "dmem_defines.svh"

module mem_request_seq
(
	input logic clock,
	input logic reset,
	input dmem_pkg::cpu_req_t req,
	output logic busy,
	output dmem_pkg::blk_req_t blk_req,
	input dmem_pkg::blk_rsp_t blk_rsp,
	output logic load_strobe,
	output dmem_pkg::mem_funct3_t load_funct3,
	output logic [3:0] load_offset,
	output logic store_done
);

	typedef enum logic [2:0]
	{
		IDLE,
		READ,
		MERGE,
		WRITE,
		FINISH
	} seq_state_t;

	seq_state_t state;
	logic accept;

	// request fields held for the whole access
	dmem_pkg::mem_op_t op_q;
	dmem_pkg::mem_funct3_t funct3_q;
	logic [`DMEM_BYTE_ADDR_SIZE-1:0] addr_q;
	dmem_pkg::dword_u wdata_q;

	// block buffer for the read-modify-write of a store
	dmem_pkg::dblock_u blk_buf;
	dmem_pkg::dword_u merged;

	// FINISH already counts as idle so a new request can follow the store_done pulse
	assign busy = (state == READ) || (state == MERGE) || (state == WRITE);
	assign accept = req.valid && !busy;

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE, FINISH:
				begin
					state <= accept ? READ : IDLE;
				end
				READ:
				begin
					// a load is finished here, a store goes on to the merge
					if (blk_rsp.ready)
					begin
						state <= (op_q == dmem_pkg::OP_LOAD) ? IDLE : MERGE;
					end
				end
				MERGE:
				begin
					state <= WRITE;
				end
				WRITE:
				begin
					if (blk_rsp.done)
					begin
						state <= FINISH;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// the addressed word with the new store bytes laid over it
	always_comb
	begin
		merged = blk_buf.words[addr_q[3:2]];
		case (funct3_q)
			dmem_pkg::SB: merged.bytes[addr_q[1:0]] = wdata_q.bytes[0];
			dmem_pkg::SH: merged.halves[addr_q[1]] = wdata_q.halves[0];
			dmem_pkg::SW: merged = wdata_q;
			default: merged = blk_buf.words[addr_q[3:2]];
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (accept && (state == IDLE || state == FINISH))
		begin
			op_q <= req.op;
			funct3_q <= req.funct3;
			addr_q <= req.addr;
			wdata_q <= req.wdata;
		end
		if (state == READ && blk_rsp.ready)
		begin
			blk_buf.bits <= blk_rsp.dout;
		end
		// the merged word goes back into its slot on the way into WRITE
		if (state == MERGE)
		begin
			blk_buf.words[addr_q[3:2]] <= merged;
		end
	end

	// memory request lines come straight from the state, so the MERGE cycle leaves both low
	assign blk_req.ren = (state == READ);
	assign blk_req.wen = (state == WRITE);
	assign blk_req.block_address = addr_q[`DMEM_BYTE_ADDR_SIZE-1:4];
	assign blk_req.din = blk_buf.bits;

	// the aligner samples the block on the cycle ready is seen
	assign load_strobe = (state == READ) && blk_rsp.ready && (op_q == dmem_pkg::OP_LOAD);
	assign load_funct3 = funct3_q;
	assign load_offset = addr_q[3:0];
	assign store_done = (state == FINISH);

	// ren must drop right after ready so the memory delay counter restarts
	assert property (@(posedge clock) disable iff (!reset)
		blk_rsp.ready && blk_req.ren |=> !blk_req.ren)
		else $error("mem_request_seq: ren held after ready");

	// a write always starts after the one idle merge cycle
	assert property (@(posedge clock) disable iff (!reset)
		$rose(blk_req.wen) |-> !$past(blk_req.ren))
		else $error("mem_request_seq: wen raised without an idle cycle after ren");

endmodule
